//--- logic/nvme_init_macros.svh
//----------------------------------------------------------
// Constants for the NVMe bring-up sequencer. Bus widths,
// the BAR assignment, controller register offsets and the
// values written during bring-up. Include this file wherever
// one of these constants is needed.
//----------------------------------------------------------
`ifndef NVME_INIT_MACROS_SVH
`define NVME_INIT_MACROS_SVH

// Requester bus widths
`define NVME_DATA_W        128
`define NVME_RQ_USER_W     62
`define NVME_KEEP_W        4

// BAR assignment
`define NVME_BAR0          64'h0000_0010_0000_0000
`define NVME_BAR_LO_VAL    32'h0000_0000
`define NVME_BAR_HI_VAL    32'h0000_0010
`define NVME_CMD_VAL       32'h0000_0007  // Mem space, I/O space, bus master

// Config space register numbers
`define NVME_CFG_CMD_REG   10'd1
`define NVME_CFG_BAR0_REG  10'd4
`define NVME_CFG_BAR1_REG  10'd5

// Controller register offsets from BAR0
`define NVME_OFS_CC        16'h0014
`define NVME_OFS_CSTS      16'h001C
`define NVME_OFS_AQA       16'h0024
`define NVME_OFS_ASQ       16'h0028
`define NVME_OFS_ACQ       16'h0030

// Register values
`define NVME_CC_DISABLE    32'h0000_0000
`define NVME_AQA_VAL       32'h000F_000F  // 16 entries each queue
`define NVME_ASQ_BASE      32'hFFFF_F100
`define NVME_ACQ_BASE      32'hFFFF_F200
`define NVME_CC_ENABLE     32'h0088_0001  // EN plus IOSQES/IOCQES

// Bus IDs and request types
`define NVME_REQUESTER_ID  16'h0000
`define NVME_COMPLETER_ID  16'h0100
`define NVME_REQ_MEMRD     4'h0
`define NVME_REQ_MEMWR     4'h1
`define NVME_REQ_CFGWR     4'hA

// Completion beat bit positions
`define NVME_CPL_OK_BIT    30
`define NVME_CPL_RDY_BIT   96

`endif

//--- logic/nvme_init_pkg.sv
//----------------------------------------------------------
// Types shared by the bring-up sequencer, the requester
// encoder and the completion decoder. Modules import this
// package in their header.
//----------------------------------------------------------
`include "nvme_init_macros.svh"

package nvme_init_pkg;

  typedef enum logic [1:0] {
    REQ_CFG_WR = 2'd0,
    REQ_MEM_WR = 2'd1,
    REQ_MEM_RD = 2'd2
  } req_kind_e;

  // One bring-up step as handed to the encoder
  typedef struct packed {
    req_kind_e   kind;
    logic [9:0]  cfg_reg;      // Cfg writes only
    logic [15:0] mem_offset;   // Added to BAR0
    logic [1:0]  dword_count;  // 1 or 2
    logic [63:0] payload;
  } init_req_t;

  // Upper descriptor half shared by both views
  typedef struct packed {
    logic        force_ecrc;
    logic [2:0]  attr;
    logic [2:0]  tc;
    logic        req_id_en;
    logic [15:0] completer_id;
    logic [7:0]  tag;
    logic [15:0] requester_id;
    logic        poisoned;
    logic [3:0]  req_type;
    logic [10:0] dword_count;
  } rq_hdr_t;

  typedef struct packed {
    rq_hdr_t     hdr;
    logic [51:0] rsvd_hi;
    logic [9:0]  reg_num;
    logic [1:0]  rsvd_lo;
  } cfg_desc_t;

  typedef struct packed {
    rq_hdr_t     hdr;
    logic [63:0] addr;
  } mem_desc_t;

  typedef union packed {
    cfg_desc_t cfg;
    mem_desc_t mem;
  } rq_desc_u;

  typedef struct packed {
    logic [`NVME_DATA_W-1:0]    tdata;
    logic [`NVME_RQ_USER_W-1:0] tuser;
    logic [`NVME_KEEP_W-1:0]    tkeep;
    logic                       tlast;
    logic                       tvalid;
  } rq_beat_t;

  typedef struct packed {
    logic done;  // One cycle per completion
    logic fail;
    logic rdy;   // Last sampled CSTS.RDY
  } cpl_result_t;

endpackage

//--- logic/init_sequencer.sv
//----------------------------------------------------------
// Bring-up FSM for the NVMe controller. On start_config it
// walks ten register steps, issuing one request per step.
// Cfg writes and CSTS reads wait for a good completion,
// memory writes are posted. cfg_done holds once finished.
//----------------------------------------------------------
`timescale 1ns/10ps
`include "nvme_init_macros.svh"

module init_sequencer
  import nvme_init_pkg::*;
(
  input  logic        user_clk,
  input  logic        reset,
  input  logic        start_config,
  input  cpl_result_t cpl,
  output init_req_t   req,
  output logic        req_issue,
  output logic        cfg_done
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_SETTLE,    // Gap for the write payload beat
    ST_WAIT_CPL,
    ST_DONE
  } seq_state_e;

  localparam logic [3:0] LAST_STEP = 4'd9;

  seq_state_e state_q;
  logic [3:0] step_q;
  logic       cpl_good;
  logic       want_rdy;

  //----------------------------------------------------------
  // Step table
  //----------------------------------------------------------
  always_comb begin
    req             = '0;
    req.dword_count = 2'd1;
    case (step_q)
      4'd0: begin
        req.kind    = REQ_CFG_WR;
        req.cfg_reg = `NVME_CFG_CMD_REG;
        req.payload = {32'd0, `NVME_CMD_VAL};
      end
      4'd1: begin
        req.kind    = REQ_CFG_WR;
        req.cfg_reg = `NVME_CFG_BAR0_REG;
        req.payload = {32'd0, `NVME_BAR_LO_VAL};
      end
      4'd2: begin
        req.kind    = REQ_CFG_WR;
        req.cfg_reg = `NVME_CFG_BAR1_REG;
        req.payload = {32'd0, `NVME_BAR_HI_VAL};
      end
      4'd3: begin
        req.kind       = REQ_MEM_WR;
        req.mem_offset = `NVME_OFS_CC;     // Controller reset
        req.payload    = {32'd0, `NVME_CC_DISABLE};
      end
      4'd4, 4'd9: begin
        req.kind       = REQ_MEM_RD;
        req.mem_offset = `NVME_OFS_CSTS;
      end
      4'd5: begin
        req.kind       = REQ_MEM_WR;
        req.mem_offset = `NVME_OFS_AQA;
        req.payload    = {32'd0, `NVME_AQA_VAL};
      end
      4'd6: begin
        req.kind        = REQ_MEM_WR;
        req.mem_offset  = `NVME_OFS_ASQ;
        req.dword_count = 2'd2;            // 64-bit base
        req.payload     = {32'd0, `NVME_ASQ_BASE};
      end
      4'd7: begin
        req.kind        = REQ_MEM_WR;
        req.mem_offset  = `NVME_OFS_ACQ;
        req.dword_count = 2'd2;
        req.payload     = {32'd0, `NVME_ACQ_BASE};
      end
      4'd8: begin
        req.kind       = REQ_MEM_WR;
        req.mem_offset = `NVME_OFS_CC;
        req.payload    = {32'd0, `NVME_CC_ENABLE};
      end
      default: ;
    endcase
  end

  //----------------------------------------------------------
  // Step FSM
  //----------------------------------------------------------
  assign cpl_good = cpl.done && !cpl.fail;  // Failed completions ignored
  assign want_rdy = (step_q == LAST_STEP);  // First poll waits for not ready

  always_ff @(posedge user_clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_config) begin
            state_q <= ST_ISSUE;
            step_q  <= '0;
          end
        end
        ST_ISSUE: state_q <= (req.kind == REQ_MEM_WR) ? ST_SETTLE : ST_WAIT_CPL;
        ST_SETTLE: begin
          step_q  <= step_q + 4'd1;
          state_q <= ST_ISSUE;
        end
        ST_WAIT_CPL: begin
          if (cpl_good) begin
            if (req.kind == REQ_MEM_RD && cpl.rdy != want_rdy) begin
              state_q <= ST_ISSUE;             // Poll again
            end else if (step_q == LAST_STEP) begin
              state_q <= ST_DONE;
            end else begin
              step_q  <= step_q + 4'd1;
              state_q <= ST_ISSUE;
            end
          end
        end
        ST_DONE: state_q <= ST_DONE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign req_issue = (state_q == ST_ISSUE);
  assign cfg_done  = (state_q == ST_DONE);

  // The encoder needs a free cycle after each issue
  assert property (@(posedge user_clk) disable iff (reset) req_issue |=> !req_issue);

  // Only reset or link loss ends the finished state
  assert property (@(posedge user_clk) cfg_done && !reset |=> cfg_done);

endmodule

//--- logic/rq_encoder.sv
//----------------------------------------------------------
// Requester encoder. Each req_issue pulse becomes a
// registered descriptor beat on the next cycle. Writes add
// a payload beat right after it. No back-pressure is taken.
//----------------------------------------------------------
`timescale 1ns/10ps
`include "nvme_init_macros.svh"

module rq_encoder
  import nvme_init_pkg::*;
(
  input  logic      user_clk,
  input  logic      reset,
  input  init_req_t req,
  input  logic      req_issue,
  output rq_beat_t  rq
);

  rq_hdr_t                    hdr;
  rq_desc_u                   desc;
  logic [3:0]                 last_be;
  logic [`NVME_RQ_USER_W-1:0] desc_user;

  logic                       tvalid_q;
  logic                       tlast_q;
  logic                       pend_q;    // Payload beat still owed
  logic [`NVME_DATA_W-1:0]    tdata_q;
  logic [`NVME_RQ_USER_W-1:0] tuser_q;
  logic [`NVME_KEEP_W-1:0]    tkeep_q;
  logic [63:0]                pay_q;
  logic [1:0]                 pay_dw_q;

  always_comb begin
    hdr              = '0;
    hdr.req_id_en    = 1'b1;
    hdr.completer_id = `NVME_COMPLETER_ID;
    hdr.requester_id = `NVME_REQUESTER_ID;
    hdr.dword_count  = {9'd0, req.dword_count};
    case (req.kind)
      REQ_CFG_WR: hdr.req_type = `NVME_REQ_CFGWR;
      REQ_MEM_WR: hdr.req_type = `NVME_REQ_MEMWR;
      default:    hdr.req_type = `NVME_REQ_MEMRD;
    endcase
  end

  // Descriptor through the view that matches the kind
  always_comb begin
    desc = '0;
    if (req.kind == REQ_CFG_WR) begin
      desc.cfg.hdr     = hdr;
      desc.cfg.reg_num = req.cfg_reg;
    end else begin
      desc.mem.hdr  = hdr;
      desc.mem.addr = `NVME_BAR0 + {48'd0, req.mem_offset};
    end
  end

  assign last_be   = (req.dword_count == 2'd2) ? 4'hF : 4'h0;
  assign desc_user = {{(`NVME_RQ_USER_W-8){1'b0}}, last_be, 4'hF};  // first_be in [3:0]

  always_ff @(posedge user_clk) begin
    if (reset) begin
      tvalid_q <= 1'b0;
      tlast_q  <= 1'b0;
      pend_q   <= 1'b0;
    end else begin
      tvalid_q <= req_issue || pend_q;
      tlast_q  <= req_issue ? (req.kind == REQ_MEM_RD) : pend_q;  // Reads are one beat
      pend_q   <= req_issue && (req.kind != REQ_MEM_RD);
    end
  end

  always_ff @(posedge user_clk) begin
    if (req_issue) begin
      tdata_q  <= desc;
      tuser_q  <= desc_user;
      tkeep_q  <= '1;
      pay_q    <= req.payload;
      pay_dw_q <= req.dword_count;
    end else if (pend_q) begin
      tdata_q <= {64'd0, pay_q};
      tuser_q <= '0;
      tkeep_q <= (pay_dw_q == 2'd2) ? 4'b0011 : 4'b0001;
    end
  end

  assign rq = {tdata_q, tuser_q, tkeep_q, tlast_q, tvalid_q};

  // Sequencer must leave room for the payload beat
  assert property (@(posedge user_clk) disable iff (reset) pend_q |-> !req_issue);

endmodule

//--- logic/rc_decoder.sv
//----------------------------------------------------------
// Completion decoder. Samples the status and CSTS.RDY bits
// on the last beat of each completion and pulses done for
// one cycle. The completer side is always ready.
//----------------------------------------------------------
`timescale 1ns/10ps
`include "nvme_init_macros.svh"

module rc_decoder
  import nvme_init_pkg::*;
(
  input  logic                    user_clk,
  input  logic                    reset,
  input  logic [`NVME_DATA_W-1:0] rc_tdata,
  input  logic                    rc_tvalid,
  input  logic                    rc_tlast,
  output cpl_result_t             cpl
);

  logic cpl_end;

  assign cpl_end = rc_tvalid && rc_tlast;

  always_ff @(posedge user_clk) begin
    if (reset) begin
      cpl <= '0;
    end else begin
      cpl.done <= cpl_end;
      if (cpl_end) begin
        cpl.fail <= ~rc_tdata[`NVME_CPL_OK_BIT];   // OK bit clear means failure
        cpl.rdy  <= rc_tdata[`NVME_CPL_RDY_BIT];
      end
    end
  end

  // A held done needs a second completion behind it
  assert property (@(posedge user_clk) disable iff (reset)
    cpl.done && !cpl_end |=> !cpl.done);

endmodule

//--- logic/nvme_init_top.sv
//----------------------------------------------------------
// Top level of the NVMe bring-up block. Connects the
// sequencer to the requester encoder and the completion
// decoder. A low link holds everything in reset.
//----------------------------------------------------------
`timescale 1ns/10ps
`include "nvme_init_macros.svh"

module nvme_init_top
  import nvme_init_pkg::*;
(
  input  logic                    user_clk,
  input  logic                    reset,
  input  logic                    user_lnk_up,
  input  logic                    start_config,
  input  logic [`NVME_DATA_W-1:0] rc_tdata,
  input  logic                    rc_tvalid,
  input  logic                    rc_tlast,
  output rq_beat_t                rq,
  output logic                    cfg_done
);

  logic        core_reset;
  init_req_t   req;
  logic        req_issue;
  cpl_result_t cpl;

  assign core_reset = reset || !user_lnk_up;  // Link loss restarts bring-up

  init_sequencer init_sequencer_i (
    .user_clk     (user_clk),
    .reset        (core_reset),
    .start_config (start_config),
    .cpl          (cpl),
    .req          (req),
    .req_issue    (req_issue),
    .cfg_done     (cfg_done)
  );

  rq_encoder rq_encoder_i (
    .user_clk  (user_clk),
    .reset     (core_reset),
    .req       (req),
    .req_issue (req_issue),
    .rq        (rq)
  );

  rc_decoder rc_decoder_i (
    .user_clk  (user_clk),
    .reset     (core_reset),
    .rc_tdata  (rc_tdata),
    .rc_tvalid (rc_tvalid),
    .rc_tlast  (rc_tlast),
    .cpl       (cpl)
  );

endmodule

//--- tb/completer_model.sv
//----------------------------------------------------------
// Endpoint model for the bring-up testbench. Captures each
// request from the RQ beats, decodes its descriptor and
// answers cfg writes and reads with one completion beat.
// Cfg writes get a rejected completion before the good one.
//----------------------------------------------------------
`timescale 1ns/10ps
`include "nvme_init_macros.svh"

module completer_model
  import nvme_init_pkg::*;
(
  input  logic                    user_clk,
  input  logic                    reset,
  input  rq_beat_t                rq,
  input  int                      n_still,     // Polls answered still ready
  input  int                      n_notyet,    // Polls answered not yet ready
  output logic [`NVME_DATA_W-1:0] rc_tdata,
  output logic                    rc_tvalid,
  output logic                    rc_tlast,
  output logic                    log_valid,
  output rq_desc_u                log_desc,
  output logic [63:0]             log_payload,
  output logic [3:0]              log_keep,
  output logic [7:0]              log_be,      // Last and first dword byte enables
  output logic                    cpl_wait     // Request still owed a good completion
);

  rq_desc_u   desc_q;
  logic [7:0] be_q;
  logic       pay_next;
  logic       target_rdy = 1'b0;   // RDY value the sequencer is polling for
  int         poll_cnt = 0;
  logic       rdy;

  //----------------------------------------------------------
  // Request capture
  //----------------------------------------------------------
  always @(posedge user_clk) begin
    log_valid <= 1'b0;
    if (reset) begin
      pay_next <= 1'b0;
    end else if (pay_next) begin
      pay_next    <= 1'b0;
      log_valid   <= 1'b1;
      log_desc    <= desc_q;
      log_be      <= be_q;
      log_payload <= rq.tdata[63:0];
      log_keep    <= rq.tkeep;
    end else if (rq.tvalid) begin
      desc_q      <= rq.tdata;
      be_q        <= rq.tuser[7:0];
      pay_next    <= !rq.tlast;       // Reads have no payload beat
      log_valid   <= rq.tlast;
      log_desc    <= rq.tdata;
      log_be      <= rq.tuser[7:0];
      log_payload <= '0;
      log_keep    <= '0;
    end
  end

  task automatic send_cpl(input logic ok, input logic rdy_bit);
    int unsigned gap;
    gap = $urandom_range(10, 2);
    repeat (gap) @(negedge user_clk);
    rc_tdata                    = '0;
    rc_tdata[`NVME_CPL_OK_BIT]  = ok;
    rc_tdata[`NVME_CPL_RDY_BIT] = rdy_bit;
    rc_tvalid                   = 1'b1;
    rc_tlast                    = 1'b1;
    @(negedge user_clk);
    rc_tvalid = 1'b0;
    rc_tlast  = 1'b0;
  endtask

  // Controller shutdown then startup, each lasting a few polls
  task automatic pick_rdy(output logic rdy_bit);
    if (!target_rdy) begin
      rdy_bit = (poll_cnt < n_still);
    end else begin
      rdy_bit = (poll_cnt >= n_notyet);
    end
    if (rdy_bit == target_rdy) begin
      target_rdy = !target_rdy;
      poll_cnt   = 0;
    end else begin
      poll_cnt++;
    end
  endtask

  //----------------------------------------------------------
  // Completion responder
  //----------------------------------------------------------
  initial begin
    rc_tdata  = '0;
    rc_tvalid = 1'b0;
    rc_tlast  = 1'b0;
    cpl_wait  = 1'b0;
    forever begin
      @(posedge user_clk);
      if (log_valid === 1'b1 && log_desc.cfg.hdr.req_type != `NVME_REQ_MEMWR) begin
        cpl_wait = 1'b1;
        if (log_desc.cfg.hdr.req_type == `NVME_REQ_CFGWR) begin
          send_cpl(1'b0, 1'b0);          // Rejected first
          send_cpl(1'b1, 1'b0);
        end else begin
          pick_rdy(rdy);
          send_cpl(1'b1, rdy);
        end
        cpl_wait = 1'b0;
      end
    end
  end

endmodule

//--- tb/tb_nvme_init.sv
//----------------------------------------------------------
// Testbench for the NVMe bring-up block. Runs the sequence
// against the endpoint model, checks each request against
// the expected step table, drops the link and runs again.
// Prints one line per test and a closing count line.
//----------------------------------------------------------
`timescale 1ns/10ps
`include "nvme_init_macros.svh"

module tb_nvme_init
  import nvme_init_pkg::*;
();

  localparam int DONE_LIMIT = 4000;   // Cycles allowed per bring-up

  logic                    user_clk;
  logic                    reset;
  logic                    user_lnk_up;
  logic                    start_config;
  logic [`NVME_DATA_W-1:0] rc_tdata;
  logic                    rc_tvalid;
  logic                    rc_tlast;
  rq_beat_t                rq;
  logic                    cfg_done;

  logic                    log_valid;
  rq_desc_u                log_desc;
  logic [63:0]             log_payload;
  logic [3:0]              log_keep;
  logic [7:0]              log_be;
  logic                    cpl_wait;
  int                      n_still;
  int                      n_notyet;

  logic [3:0]  exp_type [10];
  logic [9:0]  exp_reg  [10];
  logic [63:0] exp_addr [10];
  logic [1:0]  exp_dw   [10];
  logic [63:0] exp_pay  [10];
  logic [3:0]  exp_keep [10];
  logic [7:0]  exp_be   [10];

  int step;
  int poll_a;           // CSTS reads until not ready
  int poll_b;           // CSTS reads until ready
  int errs [1:6];
  int tests_run;
  int tests_failed;
  int total_errs;
  bit idle_phase;
  bit seen;
  bit timed_out;

  initial begin
    user_clk = 1'b0;
    forever #10 user_clk = ~user_clk;
  end

  nvme_init_top nvme_init_top_i (
    .user_clk     (user_clk),
    .reset        (reset),
    .user_lnk_up  (user_lnk_up),
    .start_config (start_config),
    .rc_tdata     (rc_tdata),
    .rc_tvalid    (rc_tvalid),
    .rc_tlast     (rc_tlast),
    .rq           (rq),
    .cfg_done     (cfg_done)
  );

  completer_model completer_model_i (
    .user_clk    (user_clk),
    .reset       (reset),
    .rq          (rq),
    .n_still     (n_still),
    .n_notyet    (n_notyet),
    .rc_tdata    (rc_tdata),
    .rc_tvalid   (rc_tvalid),
    .rc_tlast    (rc_tlast),
    .log_valid   (log_valid),
    .log_desc    (log_desc),
    .log_payload (log_payload),
    .log_keep    (log_keep),
    .log_be      (log_be),
    .cpl_wait    (cpl_wait)
  );

  task automatic value_error(input int t, input string name, input logic [63:0] got,
                             input logic [63:0] expv);
    $display("Error: %s got 0x%h expected 0x%h", name, got, expv);
    errs[t]++;
  endtask

  task automatic note_failure(input int t, input string msg);
    $display("%s", msg);
    errs[t]++;
  endtask

  task automatic set_step(input int idx, input logic [3:0] typ, input logic [9:0] reg_n,
                          input logic [15:0] ofs, input logic [1:0] dw,
                          input logic [63:0] pay);
    exp_type[idx] = typ;
    exp_reg[idx]  = reg_n;
    exp_addr[idx] = `NVME_BAR0 + {48'd0, ofs};
    exp_dw[idx]   = dw;
    exp_pay[idx]  = pay;
    exp_keep[idx] = (dw == 2'd2) ? 4'b0011 : 4'b0001;
    exp_be[idx]   = {(dw == 2'd2) ? 4'hF : 4'h0, 4'hF};  // Last dword only on 64-bit writes
  endtask

  //----------------------------------------------------------
  // Expected request table
  //----------------------------------------------------------
  initial begin
    set_step(0, `NVME_REQ_CFGWR, `NVME_CFG_CMD_REG, 16'h0, 2'd1, {32'd0, `NVME_CMD_VAL});
    set_step(1, `NVME_REQ_CFGWR, `NVME_CFG_BAR0_REG, 16'h0, 2'd1, {32'd0, `NVME_BAR_LO_VAL});
    set_step(2, `NVME_REQ_CFGWR, `NVME_CFG_BAR1_REG, 16'h0, 2'd1, {32'd0, `NVME_BAR_HI_VAL});
    set_step(3, `NVME_REQ_MEMWR, 10'd0, `NVME_OFS_CC, 2'd1, {32'd0, `NVME_CC_DISABLE});
    set_step(4, `NVME_REQ_MEMRD, 10'd0, `NVME_OFS_CSTS, 2'd1, 64'd0);
    set_step(5, `NVME_REQ_MEMWR, 10'd0, `NVME_OFS_AQA, 2'd1, {32'd0, `NVME_AQA_VAL});
    set_step(6, `NVME_REQ_MEMWR, 10'd0, `NVME_OFS_ASQ, 2'd2, {32'd0, `NVME_ASQ_BASE});
    set_step(7, `NVME_REQ_MEMWR, 10'd0, `NVME_OFS_ACQ, 2'd2, {32'd0, `NVME_ACQ_BASE});
    set_step(8, `NVME_REQ_MEMWR, 10'd0, `NVME_OFS_CC, 2'd1, {32'd0, `NVME_CC_ENABLE});
    set_step(9, `NVME_REQ_MEMRD, 10'd0, `NVME_OFS_CSTS, 2'd1, 64'd0);
  end

  task automatic check_step(input int idx);
    logic [3:0] kind;
    kind = log_desc.cfg.hdr.req_type;
    assert (kind == exp_type[idx])
      else value_error(2, $sformatf("req_type at step %0d", idx), kind, exp_type[idx]);
    assert (log_desc.cfg.hdr.dword_count == exp_dw[idx])
      else value_error(2, $sformatf("dword_count at step %0d", idx),
                       log_desc.cfg.hdr.dword_count, exp_dw[idx]);
    assert (log_be == exp_be[idx])
      else value_error(2, $sformatf("byte_enables at step %0d", idx), log_be, exp_be[idx]);
    if (exp_type[idx] == `NVME_REQ_CFGWR) begin
      assert (log_desc.cfg.reg_num == exp_reg[idx])
        else value_error(2, $sformatf("reg_num at step %0d", idx),
                         log_desc.cfg.reg_num, exp_reg[idx]);
    end else begin
      assert (log_desc.mem.addr == exp_addr[idx])
        else value_error(2, $sformatf("addr at step %0d", idx), log_desc.mem.addr,
                         exp_addr[idx]);
    end
    if (exp_type[idx] != `NVME_REQ_MEMRD) begin
      assert (log_payload == exp_pay[idx])
        else value_error(2, $sformatf("payload at step %0d", idx), log_payload, exp_pay[idx]);
      assert (log_keep == exp_keep[idx])
        else value_error(2, $sformatf("tkeep at step %0d", idx), log_keep, exp_keep[idx]);
    end
  endtask

  task automatic count_poll(input int idx);
    if (idx == 4) begin
      poll_a <= poll_a + 1;
    end else begin
      poll_b <= poll_b + 1;
    end
  endtask

  // Step tracker, a repeated CSTS read stays on its step
  always @(posedge user_clk) begin
    if (reset || !user_lnk_up) begin
      step   <= 0;
      poll_a <= 0;
      poll_b <= 0;
    end else if (log_valid) begin
      if (log_desc.cfg.hdr.req_type == `NVME_REQ_MEMRD && step > 0 &&
          exp_type[step-1] == `NVME_REQ_MEMRD) begin
        count_poll(step - 1);
      end else if (step >= 10) begin
        note_failure(2, "Request seen after the last bring-up step");
      end else begin
        check_step(step);
        if (exp_type[step] == `NVME_REQ_MEMRD) begin
          count_poll(step);
        end
        step <= step + 1;
      end
    end
  end

  //----------------------------------------------------------
  // Protocol assertions
  //----------------------------------------------------------
  assert property (@(posedge user_clk) idle_phase |-> !rq.tvalid && !cfg_done)
    else note_failure(1, "Request or cfg_done seen while idle");

  assert property (@(posedge user_clk) cpl_wait |-> !rq.tvalid)
    else note_failure(4, "Request issued before a good completion arrived");

  assert property (@(posedge user_clk) disable iff (reset || !user_lnk_up)
    rq.tvalid && !rq.tlast |=> rq.tvalid && rq.tlast)
    else note_failure(5, "Payload beat did not follow its descriptor beat");

  assert property (@(posedge user_clk) disable iff (reset) cfg_done |-> !rq.tvalid)
    else note_failure(6, "Request issued after cfg_done");

  assert property (@(posedge user_clk) disable iff (reset)
    $rose(cfg_done) |-> step == 10 && poll_b == n_notyet + 1)
    else note_failure(6, "cfg_done rose before the last ready poll");

  task automatic start_bringup();
    n_still      = $urandom_range(4, 1);
    n_notyet     = $urandom_range(4, 1);
    start_config = 1'b1;
    @(negedge user_clk);
    start_config = 1'b0;
  endtask

  task automatic wait_for_done(input int t, output bit done_seen);
    int cycles;
    done_seen = 1'b0;
    cycles    = 0;
    while (!done_seen && cycles < DONE_LIMIT) begin
      @(negedge user_clk);
      done_seen = cfg_done;
      cycles++;
    end
    if (!done_seen) begin
      note_failure(t, $sformatf("Timeout: cfg_done did not rise within %0d cycles",
                                DONE_LIMIT));
    end
  endtask

  task automatic report_test(input int t, input string name);
    tests_run++;
    if (errs[t] == 0) begin
      $display("Test %0d %s: pass", t, name);
    end else begin
      $display("Test %0d %s: fail with %0d errors", t, name, errs[t]);
      tests_failed++;
    end
  endtask

  task automatic check_polls(input int t);
    assert (step == 10) else value_error(t, "step_count", step, 10);
    assert (poll_a == n_still + 1)
      else value_error(t, "csts_reads_until_not_ready", poll_a, n_still + 1);
    assert (poll_b == n_notyet + 1)
      else value_error(t, "csts_reads_until_ready", poll_b, n_notyet + 1);
  endtask

  //----------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------
  initial begin
    void'($urandom(32'h6bca_54f0));
    errs         = '{default: 0};
    tests_run    = 0;
    tests_failed = 0;
    total_errs   = 0;
    idle_phase   = 1'b0;
    timed_out    = 1'b0;
    n_still      = 1;
    n_notyet     = 1;
    reset        = 1'b1;
    user_lnk_up  = 1'b1;
    start_config = 1'b0;
    repeat (16) @(negedge user_clk);
    reset = 1'b0;

    idle_phase = 1'b1;                       // Link up, no start
    repeat (40) @(negedge user_clk);
    idle_phase = 1'b0;
    report_test(1, "idle after reset");

    start_bringup();
    wait_for_done(2, seen);
    timed_out = !seen;
    if (seen) begin
      check_polls(3);
      report_test(2, "request sequence");
      report_test(3, "CSTS poll counts");
      report_test(4, "failed completion ignored");
      report_test(5, "write beat order");

      for (int i = 0; i < 30; i++) begin
        @(negedge user_clk);
        assert (cfg_done) else note_failure(6, "cfg_done fell with the link up");
      end
      user_lnk_up = 1'b0;                    // Link loss acts as reset
      repeat (2) @(negedge user_clk);
      assert (!cfg_done && !rq.tvalid)
        else note_failure(6, "cfg_done or tvalid stayed high after link loss");
      user_lnk_up = 1'b1;
      @(negedge user_clk);
      start_bringup();
      wait_for_done(6, seen);
      timed_out = !seen;
      if (seen) begin
        check_polls(6);
      end
      report_test(6, "hold, link loss and restart");
    end

    // Late failures of earlier tests count as well
    for (int t = 1; t <= 6; t++) begin
      total_errs += errs[t];
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (!timed_out && total_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+logic
logic/nvme_init_pkg.sv
logic/init_sequencer.sv
logic/rq_encoder.sv
logic/rc_decoder.sv
logic/nvme_init_top.sv
tb/completer_model.sv
tb/tb_nvme_init.sv
